// File: hdl/cdc_mux_pkg.sv
package cdc_mux_pkg;

   // lane count and the tag width that addresses them
   localparam int NUM_LANES = 4;
   localparam int CHAN_W = $clog2(NUM_LANES);

   // payload width, the same on both clock domains
   localparam int DATA_W = 16;

   // per-lane storage, 2**ADDR_W entries
   localparam int ADDR_W = 3;
   localparam int LANE_DEPTH = 1 << ADDR_W;

   // beat entering the write domain
   typedef struct packed {
      logic [CHAN_W-1:0] chan;
      logic [DATA_W-1:0] data;
   } wr_beat_t;

   // word held inside a lane, the tag is implied by the lane
   typedef struct packed {
      logic [DATA_W-1:0] data;
   } lane_word_t;

   // beat leaving the read domain, tag restored from the grant
   typedef struct packed {
      logic [CHAN_W-1:0] chan;
      logic [DATA_W-1:0] data;
   } rd_beat_t;

   // output arbiter states
   typedef enum logic [1:0] {
      ARB_SCAN = 2'd0,
      ARB_HOLD = 2'd1
   } arb_state_e;

endpackage

// File: hdl/lane_dispatch.sv
module lane_dispatch (
   input  logic                                  w_clk_i,
   input  logic                                  rst_n_i,
   input  logic                                  in_valid_i,
   input  cdc_mux_pkg::wr_beat_t                 in_beat_i,
   output logic                                  in_ready_o,
   input  logic [cdc_mux_pkg::NUM_LANES-1:0]     full_i,
   output logic [cdc_mux_pkg::NUM_LANES-1:0]     push_o,
   output cdc_mux_pkg::lane_word_t               push_word_o
);

   cdc_mux_pkg::wr_beat_t beat_q;
   logic                  valid_q;
   logic                  push_any;

   // decode the held channel into one strobe, only for a lane with room
   always_comb begin
      for (int k = 0; k < cdc_mux_pkg::NUM_LANES; k++) begin
         push_o[k] = valid_q && (int'(beat_q.chan) == k) && !full_i[k];
      end
   end

   assign push_any = |push_o;

   // register is free when empty or draining this cycle
   assign in_ready_o = !valid_q || push_any;

   assign push_word_o.data = beat_q.data;

   always_ff @(posedge w_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else if (in_ready_o) begin
         valid_q <= in_valid_i;
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (in_ready_o && in_valid_i) begin
         beat_q <= in_beat_i;
      end
   end

endmodule

// File: hdl/async_fifo.sv
module async_fifo (
   input  logic                    w_clk_i,
   input  logic                    r_clk_i,
   input  logic                    rst_n_i,
   input  logic                    push_i,
   input  cdc_mux_pkg::lane_word_t push_word_i,
   output logic                    full_o,
   input  logic                    pop_i,
   output logic                    empty_o,
   output cdc_mux_pkg::lane_word_t head_o
);

   // binary to gray, one bit changes per increment
   function automatic logic [cdc_mux_pkg::ADDR_W:0] bin2gray(
      input logic [cdc_mux_pkg::ADDR_W:0] bin
   );
      return bin ^ (bin >> 1);
   endfunction

   // gray back to binary, xor down from the msb
   function automatic logic [cdc_mux_pkg::ADDR_W:0] gray2bin(
      input logic [cdc_mux_pkg::ADDR_W:0] gray
   );
      logic [cdc_mux_pkg::ADDR_W:0] bin;
      bin[cdc_mux_pkg::ADDR_W] = gray[cdc_mux_pkg::ADDR_W];
      for (int i = cdc_mux_pkg::ADDR_W - 1; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

   // storage, written in the write domain and read at the read pointer
   cdc_mux_pkg::lane_word_t mem [cdc_mux_pkg::LANE_DEPTH];

   // write domain pointers, one extra wrap bit
   logic [cdc_mux_pkg::ADDR_W:0] w_bin_q;
   logic [cdc_mux_pkg::ADDR_W:0] w_bin_next;
   logic [cdc_mux_pkg::ADDR_W:0] w_gray_q;
   logic [cdc_mux_pkg::ADDR_W:0] w_rgray_meta_q;
   logic [cdc_mux_pkg::ADDR_W:0] w_rgray_sync_q;
   logic [cdc_mux_pkg::ADDR_W:0] w_rbin;
   logic [cdc_mux_pkg::ADDR_W:0] w_level;

   // read domain pointers
   logic [cdc_mux_pkg::ADDR_W:0] r_bin_q;
   logic [cdc_mux_pkg::ADDR_W:0] r_bin_next;
   logic [cdc_mux_pkg::ADDR_W:0] r_gray_q;
   logic [cdc_mux_pkg::ADDR_W:0] r_wgray_meta_q;
   logic [cdc_mux_pkg::ADDR_W:0] r_wgray_sync_q;
   logic [cdc_mux_pkg::ADDR_W:0] r_wbin;
   logic [cdc_mux_pkg::ADDR_W:0] r_level;

   assign w_bin_next = w_bin_q + 1'b1;
   assign r_bin_next = r_bin_q + 1'b1;

   // the dispatcher never pushes a full lane, so no guard here
   always_ff @(posedge w_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         w_bin_q  <= '0;
         w_gray_q <= '0;
      end else if (push_i) begin
         w_bin_q  <= w_bin_next;
         w_gray_q <= bin2gray(w_bin_next);
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (push_i) begin
         mem[w_bin_q[cdc_mux_pkg::ADDR_W-1:0]] <= push_word_i;
      end
   end

   // read gray pointer into the write domain
   always_ff @(posedge w_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         w_rgray_meta_q <= '0;
         w_rgray_sync_q <= '0;
      end else begin
         w_rgray_meta_q <= r_gray_q;
         w_rgray_sync_q <= w_rgray_meta_q;
      end
   end

   assign w_rbin  = gray2bin(w_rgray_sync_q);
   assign w_level = w_bin_q - w_rbin;
   // full when the difference reaches the depth
   assign full_o  = (w_level == {1'b1, {cdc_mux_pkg::ADDR_W{1'b0}}});

   always_ff @(posedge r_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r_bin_q  <= '0;
         r_gray_q <= '0;
      end else if (pop_i) begin
         r_bin_q  <= r_bin_next;
         r_gray_q <= bin2gray(r_bin_next);
      end
   end

   // write gray pointer into the read domain
   always_ff @(posedge r_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         r_wgray_meta_q <= '0;
         r_wgray_sync_q <= '0;
      end else begin
         r_wgray_meta_q <= w_gray_q;
         r_wgray_sync_q <= r_wgray_meta_q;
      end
   end

   assign r_wbin  = gray2bin(r_wgray_sync_q);
   assign r_level = r_wbin - r_bin_q;
   assign empty_o = (r_level == '0);

   // first-word fall-through
   assign head_o = mem[r_bin_q[cdc_mux_pkg::ADDR_W-1:0]];

endmodule

// File: hdl/lane_arbiter.sv
module lane_arbiter (
   input  logic                                                 r_clk_i,
   input  logic                                                 rst_n_i,
   input  logic [cdc_mux_pkg::NUM_LANES-1:0]                    empty_i,
   input  cdc_mux_pkg::lane_word_t [cdc_mux_pkg::NUM_LANES-1:0] head_i,
   output logic [cdc_mux_pkg::NUM_LANES-1:0]                    pop_o,
   output logic                                                 out_valid_o,
   output cdc_mux_pkg::rd_beat_t                                out_beat_o,
   input  logic                                                 out_ready_i
);

   cdc_mux_pkg::arb_state_e        state_q;
   logic [cdc_mux_pkg::CHAN_W-1:0] last_q;
   logic [cdc_mux_pkg::CHAN_W-1:0] pick;
   logic                           found;
   logic                           load;
   cdc_mux_pkg::rd_beat_t          beat_q;

   // first non-empty lane after the last grant, wrapping around
   always_comb begin
      int sum;
      found = 1'b0;
      pick  = last_q;
      for (int i = 1; i <= cdc_mux_pkg::NUM_LANES; i++) begin
         sum = (int'(last_q) + i) % cdc_mux_pkg::NUM_LANES;
         if (!found && !empty_i[sum]) begin
            found = 1'b1;
            pick  = sum[cdc_mux_pkg::CHAN_W-1:0];
         end
      end
   end

   // a stalled consumer pops nothing, in either state
   assign load = found && out_ready_i;

   always_comb begin
      pop_o = '0;
      if (load) begin
         pop_o[pick] = 1'b1;
      end
   end

   always_ff @(posedge r_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= cdc_mux_pkg::ARB_SCAN;
         // start so that lane 0 is checked first
         last_q  <= '1;
      end else begin
         case (state_q)
            cdc_mux_pkg::ARB_SCAN: begin
               if (load) begin
                  state_q <= cdc_mux_pkg::ARB_HOLD;
               end
            end
            cdc_mux_pkg::ARB_HOLD: begin
               if (out_ready_i && !found) begin
                  state_q <= cdc_mux_pkg::ARB_SCAN;
               end
            end
            default: state_q <= cdc_mux_pkg::ARB_SCAN;
         endcase
         if (load) begin
            last_q <= pick;
         end
      end
   end

   always_ff @(posedge r_clk_i) begin
      if (load) begin
         beat_q.chan <= pick;
         beat_q.data <= head_i[pick].data;
      end
   end

   assign out_valid_o = (state_q == cdc_mux_pkg::ARB_HOLD);
   assign out_beat_o  = beat_q;

endmodule

// File: hdl/cdc_mux_top.sv
module cdc_mux_top (
   input  logic                  w_clk_i,
   input  logic                  r_clk_i,
   input  logic                  rst_n_i,
   input  logic                  wr_valid_i,
   input  cdc_mux_pkg::wr_beat_t wr_beat_i,
   output logic                  wr_ready_o,
   output logic                  rd_valid_o,
   output cdc_mux_pkg::rd_beat_t rd_beat_o,
   input  logic                  rd_ready_i
);

   // write domain side of the lanes
   logic [cdc_mux_pkg::NUM_LANES-1:0] push;
   logic [cdc_mux_pkg::NUM_LANES-1:0] full;
   cdc_mux_pkg::lane_word_t           push_word;

   // read domain side of the lanes
   logic [cdc_mux_pkg::NUM_LANES-1:0]                    empty;
   logic [cdc_mux_pkg::NUM_LANES-1:0]                    pop;
   cdc_mux_pkg::lane_word_t [cdc_mux_pkg::NUM_LANES-1:0] head;

   lane_dispatch u_dispatch (
      .w_clk_i    (w_clk_i),
      .rst_n_i    (rst_n_i),
      .in_valid_i (wr_valid_i),
      .in_beat_i  (wr_beat_i),
      .in_ready_o (wr_ready_o),
      .full_i     (full),
      .push_o     (push),
      .push_word_o(push_word)
   );

   for (genvar k = 0; k < cdc_mux_pkg::NUM_LANES; k++) begin : g_lane
      async_fifo u_fifo (
         .w_clk_i    (w_clk_i),
         .r_clk_i    (r_clk_i),
         .rst_n_i    (rst_n_i),
         .push_i     (push[k]),
         .push_word_i(push_word),
         .full_o     (full[k]),
         .pop_i      (pop[k]),
         .empty_o    (empty[k]),
         .head_o     (head[k])
      );
   end

   lane_arbiter u_arbiter (
      .r_clk_i    (r_clk_i),
      .rst_n_i    (rst_n_i),
      .empty_i    (empty),
      .head_i     (head),
      .pop_o      (pop),
      .out_valid_o(rd_valid_o),
      .out_beat_o (rd_beat_o),
      .out_ready_i(rd_ready_i)
   );

endmodule

// File: bench/tb_cdc_mux_asserts.sv
module tb_cdc_mux_asserts (
   input logic                    r_clk_i,
   input logic                    rst_n_i,
   input logic                    rd_valid_i,
   input logic                    rd_ready_i,
   input cdc_mux_pkg::rd_beat_t   rd_beat_i
);

   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0;

   // a stalled beat keeps its value and stays valid
   hold_stable: assert property (@(posedge r_clk_i) disable iff (!rst_n_i)
      (rd_valid_i && !rd_ready_i) |=> (rd_valid_i && $stable(rd_beat_i)))
      else begin
         $error("rd_beat_o or rd_valid_o changed while the output was stalled");
         fail_count++;
      end

   reset_quiet: assert property (@(posedge r_clk_i) !rst_n_i |-> !rd_valid_i)
      else begin
         $error("rd_valid_o high during reset");
         fail_count++;
      end

   chan_range: assert property (@(posedge r_clk_i) disable iff (!rst_n_i)
      rd_valid_i |-> (int'(rd_beat_i.chan) < cdc_mux_pkg::NUM_LANES))
      else begin
         $error("channel tag outside the lane range");
         fail_count++;
      end

endmodule

bind cdc_mux_top tb_cdc_mux_asserts u_asserts (
   .r_clk_i    (r_clk_i),
   .rst_n_i    (rst_n_i),
   .rd_valid_i (rd_valid_o),
   .rd_ready_i (rd_ready_i),
   .rd_beat_i  (rd_beat_o)
);

// File: bench/tb_cdc_mux.sv
module tb_cdc_mux;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int HANDSHAKE_LIMIT = 500;
   localparam int DRAIN_LIMIT = 3000;
   localparam int FILL_LIMIT = 400;
   localparam int SETTLE_CYCLES = 16;
   localparam int QUIET_CYCLES = 24;

   typedef enum logic [1:0] {
      READY_HIGH,
      READY_LOW,
      READY_RANDOM
   } ready_mode_e;

   logic                  w_clk_i;
   logic                  r_clk_i;
   logic                  rst_n_i;
   logic                  wr_valid_i;
   cdc_mux_pkg::wr_beat_t wr_beat_i;
   logic                  wr_ready_o;
   logic                  rd_valid_o;
   cdc_mux_pkg::rd_beat_t rd_beat_o;
   logic                  rd_ready_i;

   cdc_mux_pkg::wr_beat_t golden [$];
   cdc_mux_pkg::rd_beat_t exp_q [cdc_mux_pkg::NUM_LANES][$];
   ready_mode_e           ready_mode;
   string                 test_name;
   int                    rx_count;
   logic [31:0]           wr_rng;
   logic [31:0]           rd_rng;

   cdc_mux_top u_cdc_mux_top (
      .w_clk_i   (w_clk_i),
      .r_clk_i   (r_clk_i),
      .rst_n_i   (rst_n_i),
      .wr_valid_i(wr_valid_i),
      .wr_beat_i (wr_beat_i),
      .wr_ready_o(wr_ready_o),
      .rd_valid_o(rd_valid_o),
      .rd_beat_o (rd_beat_o),
      .rd_ready_i(rd_ready_i)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_beat(input string test, input cdc_mux_pkg::rd_beat_t exp,
                             input cdc_mux_pkg::rd_beat_t act);
      if (act !== exp) begin
         $display("** Error [%s] expected chan %0d data %h, actual chan %0d data %h",
                  test, exp.chan, exp.data, act.chan, act.data);
         abort_run("output beat does not match the head of its channel queue");
      end
   endtask

   task automatic check_count(input string test, input int exp, input int act);
      if (act != exp) begin
         $display("** Error [%s] expected %0d beats, actual %0d beats", test, exp, act);
         abort_run("number of beats is wrong");
      end
   endtask

   task automatic check_bit(input string test, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error [%s] expected %b, actual %b", test, exp, act);
         abort_run("control signal has the wrong level");
      end
   endtask

   // the tag and data pass through a lane unchanged
   task automatic queue_expected(input cdc_mux_pkg::wr_beat_t beat);
      cdc_mux_pkg::rd_beat_t e;
      e.chan = beat.chan;
      e.data = beat.data;
      exp_q[beat.chan].push_back(e);
   endtask

   function automatic int pending_beats();
      int n;
      n = 0;
      for (int k = 0; k < cdc_mux_pkg::NUM_LANES; k++) begin
         n += exp_q[k].size();
      end
      return n;
   endfunction

   // every transfer is counted, a beat with nothing pending shows up in the count
   task automatic take_beat(input cdc_mux_pkg::rd_beat_t act);
      cdc_mux_pkg::rd_beat_t exp;
      rx_count++;
      if (exp_q[act.chan].size() != 0) begin
         exp = exp_q[act.chan].pop_front();
         check_beat(test_name, exp, act);
      end
   endtask

   // called at posedge+2, returns at posedge+2 after the transfer edge
   task automatic offer_beat(input cdc_mux_pkg::wr_beat_t beat);
      int waited;
      waited = 0;
      wr_valid_i = 1'b1;
      wr_beat_i  = beat;
      while (!wr_ready_o) begin
         @(posedge w_clk_i);
         #2;
         waited++;
         if (waited > HANDSHAKE_LIMIT) begin
            abort_run("timeout: wr_ready_o never rose for a pending write beat");
         end
      end
      @(posedge w_clk_i);
      #2;
      wr_valid_i = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      wr_valid_i = 1'b0;
      repeat (n) begin
         @(posedge w_clk_i);
         #2;
      end
   endtask

   // wait until every channel queue is empty, then look for late extras
   task automatic drain_and_count(input string test, input int sent, input int rx_start);
      int waited;
      waited = 0;
      while (pending_beats() != 0) begin
         @(negedge r_clk_i);
         waited++;
         if (waited > DRAIN_LIMIT) begin
            abort_run($sformatf("timeout: %0d beats never arrived in %s",
                                pending_beats(), test));
         end
      end
      repeat (QUIET_CYCLES) @(negedge r_clk_i);
      check_count(test, sent, rx_count - rx_start);
   endtask

   task automatic read_golden();
      int fd;
      int n;
      int fields;
      string line;
      logic [31:0] chan_v;
      logic [31:0] data_v;
      cdc_mux_pkg::wr_beat_t beat;
      fd = $fopen("bench/cdc_mux_golden.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open bench/cdc_mux_golden.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.len() > 0 && line.getc(0) != "#") begin
            fields = $sscanf(line, "%h %h", chan_v, data_v);
            if (fields == 2) begin
               beat.chan = chan_v[cdc_mux_pkg::CHAN_W-1:0];
               beat.data = data_v[cdc_mux_pkg::DATA_W-1:0];
               golden.push_back(beat);
            end
         end
      end
      $fclose(fd);
      if (golden.size() == 0) begin
         abort_run("golden file holds no beats");
      end
   endtask

   initial begin
      w_clk_i = 1'b0;
      forever #10 w_clk_i = ~w_clk_i;
   end

   initial begin
      r_clk_i = 1'b0;
      forever #17 r_clk_i = ~r_clk_i;
   end

   // read side: drive rd_ready_i and score every committed transfer
   initial begin
      forever begin
         @(posedge r_clk_i);
         #2;
         case (ready_mode)
            READY_HIGH: rd_ready_i = 1'b1;
            READY_LOW:  rd_ready_i = 1'b0;
            default: begin
               rd_rng     = xorshift32(rd_rng);
               rd_ready_i = (rd_rng % 3) != 0;
            end
         endcase
         if (rd_valid_o && rd_ready_i) begin
            take_beat(rd_beat_o);
         end
         if (u_cdc_mux_top.u_asserts.fail_count != 0) begin
            abort_run("a bound assertion on the read stream failed");
         end
      end
   end

   initial begin
      int rx_start;
      int accepted;
      int low_run;
      int cycles;
      cdc_mux_pkg::wr_beat_t beat;

      rst_n_i    = 1'b0;
      wr_valid_i = 1'b0;
      wr_beat_i  = '0;
      rd_ready_i = 1'b0;
      ready_mode = READY_HIGH;
      test_name  = "reset";
      rx_count   = 0;
      wr_rng     = 32'h4361;
      rd_rng     = xorshift32(32'h4361);

      read_golden();
      repeat (8) @(posedge w_clk_i);
      #2;
      rst_n_i = 1'b1;
      @(posedge w_clk_i);
      #2;
      check_bit("reset rd_valid_o", 1'b0, rd_valid_o);
      check_bit("reset wr_ready_o", 1'b1, wr_ready_o);

      test_name = "ordered stream";
      rx_start  = rx_count;
      foreach (golden[i]) begin
         queue_expected(golden[i]);
         offer_beat(golden[i]);
      end
      drain_and_count(test_name, golden.size(), rx_start);

      // lane 0 fills while the read side is stalled
      test_name  = "backpressure";
      ready_mode = READY_LOW;
      rx_start   = rx_count;
      accepted   = 0;
      low_run    = 0;
      cycles     = 0;
      beat.chan  = '0;
      beat.data  = 16'hb000;
      queue_expected(beat);
      wr_valid_i = 1'b1;
      wr_beat_i  = beat;
      while (low_run < SETTLE_CYCLES) begin
         if (wr_ready_o) begin
            accepted++;
            low_run = 0;
            @(posedge w_clk_i);
            #2;
            beat.data = beat.data + 1'b1;
            queue_expected(beat);
            wr_beat_i = beat;
         end else begin
            low_run++;
            @(posedge w_clk_i);
            #2;
         end
         cycles++;
         if (cycles > FILL_LIMIT) begin
            abort_run("timeout: wr_ready_o never stayed low while filling lane 0");
         end
      end
      // lane depth plus the dispatcher register
      check_count("backpressure fill", cdc_mux_pkg::LANE_DEPTH + 1, accepted);
      ready_mode = READY_HIGH;
      offer_beat(beat);
      drain_and_count(test_name, accepted + 1, rx_start);

      test_name  = "random stalls";
      ready_mode = READY_RANDOM;
      rx_start   = rx_count;
      foreach (golden[i]) begin
         wr_rng = xorshift32(wr_rng);
         if (wr_rng[2]) begin
            idle_cycles(int'(wr_rng[1:0]));
         end
         queue_expected(golden[i]);
         offer_beat(golden[i]);
      end
      drain_and_count(test_name, golden.size(), rx_start);
      ready_mode = READY_HIGH;
      repeat (4) @(negedge r_clk_i);

      if (u_cdc_mux_top.u_asserts.fail_count == 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         abort_run("bound assertions reported failures");
      end
   end

endmodule

// File: bench/cdc_mux_golden.txt
# columns: channel (hex, 0 to 3) and data word (hex, 16 bits)
# each line is one write beat and also the next expected beat of its channel
0 1a00
1 2b01
2 3c02
3 4d03
0 1a04
0 1a05
1 2b06
3 4d07
2 3c08
2 3c09
2 3c0a
2 3c0b
2 3c0c
2 3c0d
2 3c0e
2 3c0f
2 3c10
2 3c11
2 3c12
1 2b13
0 1a14
3 4d15
3 4d16
1 2b17
0 1a18
2 3c19
3 4d1a
1 2b1b
0 1a1c
0 1a1d
3 4d1e
1 2b1f
2 3c20
0 1a21

// File: tb.f
hdl/cdc_mux_pkg.sv
hdl/lane_dispatch.sv
hdl/async_fifo.sv
hdl/lane_arbiter.sv
hdl/cdc_mux_top.sv
bench/tb_cdc_mux_asserts.sv
bench/tb_cdc_mux.sv

// File: Bender.yml
package:
  name: cdc_mux

sources:
  - hdl/cdc_mux_pkg.sv
  - hdl/lane_dispatch.sv
  - hdl/async_fifo.sv
  - hdl/lane_arbiter.sv
  - hdl/cdc_mux_top.sv
  - target: test
    files:
      - bench/tb_cdc_mux_asserts.sv
      - bench/tb_cdc_mux.sv
